// File: rtl/uart_baud_gen.sv
`default_nettype none

module uart_baud_gen (
	input logic clk,
	input logic rst_n,
	input logic [uart_pkg::DIV_W-1:0] div,
	output logic tick
);

	// Down-counter, one tick per div+1 clocks
	logic [uart_pkg::DIV_W-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= uart_pkg::DIV_RESET;
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			// New divisor only picked up here
			cnt <= div;
			tick <= 1'b1;
		end
		else
		begin
			cnt <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_ctrl_if.sv
`default_nettype none

interface uart_ctrl_if;

	// From the register decoder
	logic [uart_pkg::DIV_W-1:0] div;
	byte tx_data;
	logic tx_start;
	logic rx_pop;

	// From the UART core
	logic tx_busy;
	byte rx_data;
	logic rx_empty;
	logic rx_overrun;
	logic rx_frame_err;

	modport decoder (
		output div, tx_data, tx_start, rx_pop,
		input tx_busy, rx_data, rx_empty, rx_overrun, rx_frame_err
	);

	modport core (
		input div, tx_data, tx_start, rx_pop,
		output tx_busy, rx_data, rx_empty, rx_overrun, rx_frame_err
	);

endinterface

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

	////////////////////
	// Bus and register widths
	localparam int WB_DW = 16;
	localparam int WB_AW = 2;
	localparam int DIV_W = 16;

	// Tick every 4 clocks after reset, so one bit is 64 clocks
	localparam logic [DIV_W-1:0] DIV_RESET = 16'd3;

	////////////////////
	// Serial timing
	localparam int OVERSAMPLE = 16;
	localparam int TICK_W = $clog2(OVERSAMPLE);
	// Tick count at the mid-point of the start bit
	localparam int HALF_BIT = OVERSAMPLE / 2;

	// Receive buffer
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	////////////////////
	// Register map, used as decoder opcodes
	typedef enum logic [WB_AW-1:0] {
		REG_DATA = 2'd0,
		REG_STATUS = 2'd1,
		REG_DIV = 2'd2
	} reg_addr_t;

	// Status word bit positions
	localparam int STAT_RX_READY = 0;
	localparam int STAT_TX_BUSY = 1;
	localparam int STAT_OVERRUN = 2;
	localparam int STAT_FRAME_ERR = 3;

	// State machines
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

// File: rtl/uart_rx.sv
`default_nettype none

module uart_rx (
	input logic clk,
	input logic rst_n,
	input logic rxd,
	input logic tick,
	output byte data,
	output logic push,
	output logic frame_err
);

	uart_pkg::rx_state_t state;

	// Line synchronizer, idles high
	logic rxd_meta;
	logic rxd_s;

	// Ticks within a bit, and data bit index
	logic [uart_pkg::TICK_W-1:0] tcnt;
	logic [2:0] bcnt;
	logic [7:0] shreg;

	logic mid_start;
	logic bit_end;

	assign mid_start = (tcnt == uart_pkg::TICK_W'(uart_pkg::HALF_BIT - 1));
	assign bit_end = (tcnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE - 1));
	assign data = shreg;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rxd_meta <= 1'b1;
			rxd_s <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_s <= rxd_meta;
		end
	end

	////////////////////
	// Receive state machine
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= uart_pkg::RX_IDLE;
			tcnt <= '0;
			bcnt <= '0;
			push <= 1'b0;
			frame_err <= 1'b0;
		end
		else
		begin
			// Pulses last one clock
			push <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE:
				begin
					tcnt <= '0;
					bcnt <= '0;
					// Falling edge on the line
					if (!rxd_s)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START:
				begin
					if (tick)
					begin
						tcnt <= tcnt + 1'b1;
						if (mid_start)
						begin
							tcnt <= '0;
							// Line back high means a glitch, not a start bit
							if (rxd_s)
								state <= uart_pkg::RX_IDLE;
							else
								state <= uart_pkg::RX_DATA;
						end
					end
				end
				uart_pkg::RX_DATA:
				begin
					if (tick)
					begin
						// Wraps to zero after the last tick of a bit
						tcnt <= tcnt + 1'b1;
						if (bit_end)
						begin
							bcnt <= bcnt + 1'b1;
							if (bcnt == 3'd7)
								state <= uart_pkg::RX_STOP;
						end
					end
				end
				uart_pkg::RX_STOP:
				begin
					if (tick)
					begin
						tcnt <= tcnt + 1'b1;
						if (bit_end)
						begin
							// Stop bit must be high to keep the byte
							push <= rxd_s;
							frame_err <= !rxd_s;
							state <= uart_pkg::RX_IDLE;
						end
					end
				end
				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits come in LSB first
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::RX_DATA && tick && bit_end)
			shreg <= {rxd_s, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx_fifo.sv
`default_nettype none

module uart_rx_fifo (
	input logic clk,
	input logic rst_n,
	input logic push,
	input logic pop,
	input byte wdata,
	output byte rdata,
	output logic empty,
	output logic overrun
);

	byte mem [uart_pkg::FIFO_DEPTH];

	logic [uart_pkg::FIFO_AW-1:0] wptr;
	logic [uart_pkg::FIFO_AW-1:0] rptr;
	// One bit wider than the pointers to tell full from empty
	logic [uart_pkg::FIFO_AW:0] count;

	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == (uart_pkg::FIFO_AW + 1)'(uart_pkg::FIFO_DEPTH));
	assign do_pop = pop && !empty;
	// A pop on the same clock frees a slot
	assign do_push = push && (!full || do_pop);

	// Head word, no read latency
	assign rdata = mem[rptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wptr] <= wdata;
	end

	////////////////////
	// Pointers and fill level
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			if (do_push)
				wptr <= wptr + 1'b1;
			if (do_pop)
				rptr <= rptr + 1'b1;
			count <= count + do_push - do_pop;
			// New byte dropped, stored bytes kept
			overrun <= push && !do_push;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`default_nettype none

module uart_top (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [uart_pkg::WB_AW-1:0] wb_adr,
	input logic [uart_pkg::WB_DW-1:0] wb_dat_i,
	output logic [uart_pkg::WB_DW-1:0] wb_dat_o,
	output logic wb_ack,
	input logic rxd,
	output logic txd
);

	uart_ctrl_if ctrl ();

	// Oversample tick shared by both directions
	logic tick;
	// Receiver to FIFO
	byte rx_byte;
	logic rx_push;

	////////////////////
	// Bus side
	uart_wb_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack),
		.ctrl(ctrl.decoder)
	);

	////////////////////
	// Serial core
	uart_baud_gen u_baud (
		.clk(clk),
		.rst_n(rst_n),
		.div(ctrl.div),
		.tick(tick)
	);

	uart_tx u_tx (
		.clk(clk),
		.rst_n(rst_n),
		.tick(tick),
		.start(ctrl.tx_start),
		.data(ctrl.tx_data),
		.txd(txd),
		.busy(ctrl.tx_busy)
	);

	uart_rx u_rx (
		.clk(clk),
		.rst_n(rst_n),
		.rxd(rxd),
		.tick(tick),
		.data(rx_byte),
		.push(rx_push),
		.frame_err(ctrl.rx_frame_err)
	);

	// Received bytes wait here for the bus
	uart_rx_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(rx_push),
		.pop(ctrl.rx_pop),
		.wdata(rx_byte),
		.rdata(ctrl.rx_data),
		.empty(ctrl.rx_empty),
		.overrun(ctrl.rx_overrun)
	);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`default_nettype none

module uart_tx (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input logic start,
	input byte data,
	output logic txd,
	output logic busy
);

	uart_pkg::tx_state_t state;

	// Byte accepted, waiting for the next tick to open the start bit
	logic pend;
	logic load;
	logic bit_end;

	logic [uart_pkg::TICK_W-1:0] tcnt;
	logic [2:0] bcnt;
	logic [7:0] shreg;

	assign load = start && !pend && (state == uart_pkg::TX_IDLE);
	assign bit_end = (tcnt == uart_pkg::TICK_W'(uart_pkg::OVERSAMPLE - 1));
	assign busy = pend || (state != uart_pkg::TX_IDLE);

	////////////////////
	// Transmit state machine
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= uart_pkg::TX_IDLE;
			pend <= 1'b0;
			tcnt <= '0;
			bcnt <= '0;
			txd <= 1'b1;
		end
		else
		begin
			case (state)
				uart_pkg::TX_IDLE:
				begin
					txd <= 1'b1;
					if (load)
						pend <= 1'b1;
					else if (pend && tick)
					begin
						// Start bit goes out on this tick
						pend <= 1'b0;
						tcnt <= '0;
						txd <= 1'b0;
						state <= uart_pkg::TX_START;
					end
				end
				uart_pkg::TX_START:
				begin
					if (tick)
					begin
						tcnt <= tcnt + 1'b1;
						if (bit_end)
						begin
							bcnt <= '0;
							txd <= shreg[0];
							state <= uart_pkg::TX_DATA;
						end
					end
				end
				uart_pkg::TX_DATA:
				begin
					if (tick)
					begin
						tcnt <= tcnt + 1'b1;
						if (bit_end)
						begin
							bcnt <= bcnt + 1'b1;
							// Next bit is shreg[1] since shreg shifts on this edge
							txd <= (bcnt == 3'd7) ? 1'b1 : shreg[1];
							if (bcnt == 3'd7)
								state <= uart_pkg::TX_STOP;
						end
					end
				end
				uart_pkg::TX_STOP:
				begin
					if (tick)
					begin
						tcnt <= tcnt + 1'b1;
						if (bit_end)
							state <= uart_pkg::TX_IDLE;
					end
				end
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// Byte shifts right, LSB on the line
	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= data;
		else if (state == uart_pkg::TX_DATA && tick && bit_end)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

// File: rtl/uart_wb_regs.sv
`default_nettype none

module uart_wb_regs (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [uart_pkg::WB_AW-1:0] wb_adr,
	input logic [uart_pkg::WB_DW-1:0] wb_dat_i,
	output logic [uart_pkg::WB_DW-1:0] wb_dat_o,
	output logic wb_ack,
	uart_ctrl_if.decoder ctrl
);

	uart_pkg::reg_addr_t addr;

	// New request, not yet acknowledged
	logic req;
	logic wr;
	logic rd;

	// Sticky error bits
	logic overrun_q;
	logic frame_err_q;

	logic [uart_pkg::WB_DW-1:0] status;

	assign addr = uart_pkg::reg_addr_t'(wb_adr);
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign wr = req && wb_we;
	assign rd = req && !wb_we;

	always_comb
	begin
		status = '0;
		status[uart_pkg::STAT_RX_READY] = !ctrl.rx_empty;
		status[uart_pkg::STAT_TX_BUSY] = ctrl.tx_busy;
		status[uart_pkg::STAT_OVERRUN] = overrun_q;
		status[uart_pkg::STAT_FRAME_ERR] = frame_err_q;
	end

	////////////////////
	// Ack, control pulses and register state
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			ctrl.tx_start <= 1'b0;
			ctrl.rx_pop <= 1'b0;
			ctrl.div <= uart_pkg::DIV_RESET;
			overrun_q <= 1'b0;
			frame_err_q <= 1'b0;
		end
		else
		begin
			// All pulses line up with ack
			wb_ack <= req;
			ctrl.tx_start <= wr && (addr == uart_pkg::REG_DATA) && !ctrl.tx_busy;
			ctrl.rx_pop <= rd && (addr == uart_pkg::REG_DATA) && !ctrl.rx_empty;
			if (wr && addr == uart_pkg::REG_DIV)
				ctrl.div <= wb_dat_i;
			// Read clears, a new event in the same clock wins
			if (rd && addr == uart_pkg::REG_STATUS)
			begin
				overrun_q <= 1'b0;
				frame_err_q <= 1'b0;
			end
			if (ctrl.rx_overrun)
				overrun_q <= 1'b1;
			if (ctrl.rx_frame_err)
				frame_err_q <= 1'b1;
		end
	end

	// Transmit byte, taken from the low half of the bus
	always_ff @(posedge clk)
	begin
		if (wr && addr == uart_pkg::REG_DATA && !ctrl.tx_busy)
			ctrl.tx_data <= wb_dat_i[7:0];
	end

	// Read data, zero outside the ack cycle
	always_ff @(posedge clk)
	begin
		wb_dat_o <= '0;
		if (rd)
		begin
			case (addr)
				uart_pkg::REG_DATA:
					// Empty FIFO reads as zero
					wb_dat_o <= ctrl.rx_empty ? '0 : {8'h00, ctrl.rx_data};
				uart_pkg::REG_STATUS:
					wb_dat_o <= status;
				uart_pkg::REG_DIV:
					wb_dat_o <= ctrl.div;
				default:
					wb_dat_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/uart_pkg.sv
rtl/uart_ctrl_if.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_rx_fifo.sv
rtl/uart_wb_regs.sv
rtl/uart_top.sv
testbench/tb_clock_gen.sv
testbench/uart_checker.sv
testbench/uart_tb.sv

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset low over two rising edges, released on a falling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/uart_checker.sv
`default_nettype none

module uart_checker (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [uart_pkg::WB_AW-1:0] wb_adr,
	input logic wb_ack,
	input logic txd,
	input logic rx_pop,
	input logic rx_empty
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far, read by the testbench
	int assert_fails = 0;

	// Set once the first DATA write is acknowledged
	logic data_written;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			data_written <= 1'b0;
		else if (wb_ack && wb_we && wb_adr == uart_pkg::REG_DATA)
			data_written <= 1'b1;
	end

	////////////////////
	// Bus handshake
	ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
	else
	begin
		assert_fails++;
		$error("ack raised outside a valid bus cycle");
	end

	ack_one_clock: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
	else
	begin
		assert_fails++;
		$error("ack held high for two clocks");
	end

	////////////////////
	// Serial line and receive buffer
	txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		!data_written |-> txd)
	else
	begin
		assert_fails++;
		$error("txd low before any DATA write");
	end

	no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rx_pop |-> !rx_empty)
	else
	begin
		assert_fails++;
		$error("FIFO popped while empty");
	end

endmodule

bind uart_top uart_checker chk (
	.clk(clk),
	.rst_n(rst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_ack(wb_ack),
	.txd(txd),
	.rx_pop(ctrl.rx_pop),
	.rx_empty(ctrl.rx_empty)
);

`default_nettype wire

// File: testbench/uart_tb.sv
`default_nettype none

module uart_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Clock budgets for the bounded waits
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 2000;
	localparam int EDGE_LIMIT = 4000;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [uart_pkg::WB_AW-1:0] wb_adr;
	logic [uart_pkg::WB_DW-1:0] wb_dat_i;
	logic [uart_pkg::WB_DW-1:0] wb_dat_o;
	logic wb_ack;
	logic rxd;
	logic txd;

	// Serial source select, txd or the drive task
	logic loopback;
	logic rxd_drv;

	int value_errs;
	int timeout_errs;
	// Divisor the DUT runs with
	int cur_div;

	assign rxd = loopback ? txd : rxd_drv;

	tb_clock_gen u_clk (
		.clk(clk),
		.rst_n(rst_n)
	);

	uart_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack),
		.rxd(rxd),
		.txd(txd)
	);

	// Clocks per serial bit
	function automatic int bit_clocks();
		return (cur_div + 1) * 16;
	endfunction

	////////////////////
	// Compare tasks
	task automatic check_word(input logic [uart_pkg::WB_DW-1:0] got,
		input logic [uart_pkg::WB_DW-1:0] exp, input string what);
		if (got !== exp)
		begin
			value_errs++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input logic [uart_pkg::WB_DW-1:0] got,
		input logic rx_ready, input logic tx_busy, input logic overrun,
		input logic frame_err, input string what);
		logic [uart_pkg::WB_DW-1:0] exp;
		exp = '0;
		exp[uart_pkg::STAT_RX_READY] = rx_ready;
		exp[uart_pkg::STAT_TX_BUSY] = tx_busy;
		exp[uart_pkg::STAT_OVERRUN] = overrun;
		exp[uart_pkg::STAT_FRAME_ERR] = frame_err;
		if (got !== exp)
		begin
			value_errs++;
			$display("[FAIL] %0t ns: %s rx_ready=%b tx_busy=%b overrun=%b frame_err=%b, %s",
				$time, what, got[uart_pkg::STAT_RX_READY], got[uart_pkg::STAT_TX_BUSY],
				got[uart_pkg::STAT_OVERRUN], got[uart_pkg::STAT_FRAME_ERR],
				$sformatf("expected %b%b%b%b (frame_err..rx_ready)",
				frame_err, overrun, tx_busy, rx_ready));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
		begin
			value_errs++;
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////
	// Bus tasks
	task automatic bus_cycle(input logic we, input uart_pkg::reg_addr_t adr,
		input logic [uart_pkg::WB_DW-1:0] wdata, output logic [uart_pkg::WB_DW-1:0] rdata);
		int n;
		rdata = '0;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = wdata;
		@(negedge clk);
		n = 1;
		while (!wb_ack && n < ACK_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack)
		begin
			timeout_errs++;
			$display("Timeout: no bus acknowledge for address %0d", adr);
		end
		else
			rdata = wb_dat_o;
		// Keep the request over the edge where ack falls
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_write(input uart_pkg::reg_addr_t adr,
		input logic [uart_pkg::WB_DW-1:0] data);
		logic [uart_pkg::WB_DW-1:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input uart_pkg::reg_addr_t adr,
		output logic [uart_pkg::WB_DW-1:0] data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	// Polls STATUS until a byte is waiting
	task automatic poll_rx_ready(output logic [uart_pkg::WB_DW-1:0] status);
		int n;
		n = 0;
		wb_read(uart_pkg::REG_STATUS, status);
		while (!status[uart_pkg::STAT_RX_READY] && n < POLL_LIMIT)
		begin
			wb_read(uart_pkg::REG_STATUS, status);
			n++;
		end
		if (!status[uart_pkg::STAT_RX_READY])
		begin
			timeout_errs++;
			$display("Timeout: no received byte showed up in STATUS");
		end
	endtask

	task automatic wait_tx_idle();
		logic [uart_pkg::WB_DW-1:0] status;
		int n;
		n = 0;
		wb_read(uart_pkg::REG_STATUS, status);
		while (status[uart_pkg::STAT_TX_BUSY] && n < POLL_LIMIT)
		begin
			wb_read(uart_pkg::REG_STATUS, status);
			n++;
		end
		if (status[uart_pkg::STAT_TX_BUSY])
		begin
			timeout_errs++;
			$display("Timeout: transmitter stayed busy");
		end
	endtask

	////////////////////
	// Serial tasks
	task automatic drive_level(input logic level, input int clocks);
		rxd_drv = level;
		repeat (clocks) @(negedge clk);
	endtask

	task automatic send_serial_frame(input logic [7:0] data, input logic stop_ok);
		int i;
		drive_level(1'b0, bit_clocks());
		for (i = 0; i < 8; i++)
			drive_level(data[i], bit_clocks());
		if (stop_ok)
			drive_level(1'b1, bit_clocks());
		else
		begin
			// Low across the stop sample point, high before the next start check
			drive_level(1'b0, bit_clocks() * 3 / 4);
			drive_level(1'b1, bit_clocks() / 4);
		end
	endtask

	// Clocks that txd spends low from its next falling edge
	task automatic measure_start_bit(output int len);
		int n;
		n = 0;
		len = 0;
		while (txd && n < EDGE_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (txd)
		begin
			timeout_errs++;
			$display("Timeout: txd never went low for a start bit");
		end
		else
		begin
			while (!txd && len < EDGE_LIMIT)
			begin
				@(negedge clk);
				len++;
			end
			if (!txd)
			begin
				timeout_errs++;
				$display("Timeout: txd stayed low past the start bit");
			end
		end
	endtask

	////////////////////
	// Directed tests
	task automatic reset_defaults();
		logic [uart_pkg::WB_DW-1:0] rd;
		int low_clocks;
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b0, 1'b0, 1'b0, 1'b0, "status after reset");
		wb_read(uart_pkg::REG_DIV, rd);
		check_word(rd, uart_pkg::WB_DW'(uart_pkg::DIV_RESET), "divisor after reset");
		low_clocks = 0;
		repeat (4 * bit_clocks())
		begin
			@(negedge clk);
			if (txd !== 1'b1)
				low_clocks++;
		end
		check_count(low_clocks, 0, "txd low clocks while idle");
	endtask

	task automatic loopback_single_byte();
		logic [uart_pkg::WB_DW-1:0] rd;
		loopback = 1'b1;
		wb_write(uart_pkg::REG_DATA, 16'h00a5);
		poll_rx_ready(rd);
		wb_read(uart_pkg::REG_DATA, rd);
		check_word(rd, 16'h00a5, "loopback byte");
		wait_tx_idle();
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b0, 1'b0, 1'b0, 1'b0, "status after loopback read");
	endtask

	task automatic random_bytes_new_divisor();
		logic [uart_pkg::WB_DW-1:0] rd;
		logic [7:0] b;
		int len;
		int i;
		cur_div = 5;
		wb_write(uart_pkg::REG_DIV, 16'd5);
		wb_read(uart_pkg::REG_DIV, rd);
		check_word(rd, 16'd5, "divisor readback");
		loopback = 1'b1;
		for (i = 0; i < 4; i++)
		begin
			b = 8'($urandom);
			// Odd first byte, so the start bit stands alone on the line
			if (i == 0)
				b[0] = 1'b1;
			wb_write(uart_pkg::REG_DATA, {8'h00, b});
			measure_start_bit(len);
			if (b[0])
				check_count(len, (cur_div + 1) * 16, "start bit clocks");
			poll_rx_ready(rd);
			wb_read(uart_pkg::REG_DATA, rd);
			check_word(rd, {8'h00, b}, "random loopback byte");
			wait_tx_idle();
		end
	endtask

	task automatic fifo_overrun();
		logic [uart_pkg::WB_DW-1:0] rd;
		logic [7:0] frames [uart_pkg::FIFO_DEPTH + 1];
		int i;
		loopback = 1'b0;
		for (i = 0; i <= uart_pkg::FIFO_DEPTH; i++)
		begin
			frames[i] = 8'($urandom);
			send_serial_frame(frames[i], 1'b1);
		end
		drive_level(1'b1, 2 * bit_clocks());
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b1, 1'b0, 1'b1, 1'b0, "status after overrun");
		// Oldest bytes kept, last one dropped
		for (i = 0; i < uart_pkg::FIFO_DEPTH; i++)
		begin
			wb_read(uart_pkg::REG_DATA, rd);
			check_word(rd, {8'h00, frames[i]}, "buffered byte");
		end
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b0, 1'b0, 1'b0, 1'b0, "status after overrun clear");
	endtask

	task automatic frame_error_and_glitch();
		logic [uart_pkg::WB_DW-1:0] rd;
		loopback = 1'b0;
		send_serial_frame(8'h3c, 1'b0);
		drive_level(1'b1, 2 * bit_clocks());
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b0, 1'b0, 1'b0, 1'b1, "status after low stop bit");
		// Quarter-bit pulse, well short of the mid-start sample
		drive_level(1'b0, bit_clocks() / 4);
		drive_level(1'b1, 12 * bit_clocks());
		wb_read(uart_pkg::REG_STATUS, rd);
		check_status(rd, 1'b0, 1'b0, 1'b0, 1'b0, "status after glitch");
		wb_read(uart_pkg::REG_DATA, rd);
		check_word(rd, 16'h0000, "data read with empty buffer");
	endtask

	////////////////////
	// Sequence and verdict
	initial
	begin
		int n;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		loopback = 1'b0;
		rxd_drv = 1'b1;
		value_errs = 0;
		timeout_errs = 0;
		cur_div = int'(uart_pkg::DIV_RESET);
		void'($urandom(18));
		n = 0;
		while (rst_n !== 1'b1 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
		begin
			timeout_errs++;
			$display("Timeout: reset was never released");
		end
		reset_defaults();
		loopback_single_byte();
		random_bytes_new_divisor();
		fifo_overrun();
		frame_error_and_glitch();
		$display("Errors: %0d value, %0d timeout, %0d assertion",
			value_errs, timeout_errs, dut.chk.assert_fails);
		if (value_errs == 0 && timeout_errs == 0 && dut.chk.assert_fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
